//--- compile.f
logic/datapath_pkg.sv
logic/fetch_if.sv
logic/issue_if.sv
logic/result_if.sv
logic/fetch.sv
logic/scoreboard.sv
logic/execute.sv
logic/writeback.sv
logic/sc_datapath.sv
tests/tb_sc_datapath.sv

//--- logic/datapath_pkg.sv
// scalar datapath definitions
package datapath_pkg;

    // widths
    localparam int WORD_W = 32;
    localparam int PC_W   = 16;
    localparam int REG_W  = 3;
    localparam int NREGS  = 2 ** REG_W;

    // instruction field positions
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 25;
    localparam int RS1_HI = 24;
    localparam int RS1_LO = 22;
    localparam int RS2_HI = 21;
    localparam int RS2_LO = 19;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_BEQ  = 4'h7,
        OP_BNE  = 4'h8,
        OP_HALT = 4'hf
    } opcode_t;

    // decoded packet from scoreboard to execute
    typedef struct packed {
        opcode_t           opcode;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] rdat1;
        logic [WORD_W-1:0] rdat2;
        logic [WORD_W-1:0] imm;
        logic [PC_W-1:0]   pc;
    } issue_t;

    typedef struct packed {
        logic              wen;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] data;
        logic              halt;
    } result_t;

    typedef struct packed {
        logic            taken;
        logic [PC_W-1:0] target;
    } redirect_t;

endpackage

//--- logic/execute.sv
// scalar ALU and branch unit
`timescale 1ns/100ps

module execute (
    input logic     CLK,
    input logic     nrst,
    issue_if.exec   iif,
    result_if.exec  rif
);
    import datapath_pkg::*;

    logic [WORD_W-1:0] a, b;
    logic [WORD_W-1:0] alu_out;
    logic              alu_wen;
    logic              br_taken;
    logic [PC_W-1:0]   br_target;
    logic              valid_q;
    result_t           res_q;
    redirect_t         redir_q;

    assign a = iif.pkt.rdat1;
    assign b = iif.pkt.rdat2;

    always_comb begin
        alu_out  = '0;
        alu_wen  = 1'b0;
        br_taken = 1'b0;
        case (iif.pkt.opcode)
            OP_ADD:  begin alu_out = a + b;           alu_wen = 1'b1; end
            OP_SUB:  begin alu_out = a - b;           alu_wen = 1'b1; end
            OP_AND:  begin alu_out = a & b;           alu_wen = 1'b1; end
            OP_OR:   begin alu_out = a | b;           alu_wen = 1'b1; end
            OP_XOR:  begin alu_out = a ^ b;           alu_wen = 1'b1; end
            OP_ADDI: begin alu_out = a + iif.pkt.imm; alu_wen = 1'b1; end
            OP_BEQ:  br_taken = (a == b);
            OP_BNE:  br_taken = (a != b);
            default: ;
        endcase
    end

    // target wraps in the word-addressed pc space
    assign br_target = iif.pkt.pc + iif.pkt.imm[PC_W-1:0];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
            res_q   <= '0;
            redir_q <= '0;
        end else begin
            valid_q      <= iif.valid;
            // register 0 writes vanish here
            res_q.wen    <= iif.valid && alu_wen && (iif.pkt.rd != '0);
            res_q.rd     <= iif.pkt.rd;
            res_q.data   <= alu_out;
            res_q.halt   <= iif.valid && (iif.pkt.opcode == OP_HALT);
            redir_q.taken  <= iif.valid && br_taken;
            redir_q.target <= br_target;
        end
    end

    assign rif.valid = valid_q;
    assign rif.res   = res_q;
    assign rif.redir = redir_q;

endmodule

//--- logic/fetch.sv
// instruction fetch stage
`timescale 1ns/100ps

module fetch #(
    parameter logic [datapath_pkg::PC_W-1:0] RESET_PC = '0
) (
    input  logic                              CLK,
    input  logic                              nrst,
    output logic                              imem_ren,
    output logic [datapath_pkg::PC_W-1:0]     imem_addr,
    input  logic                              imem_hit,
    input  logic [datapath_pkg::WORD_W-1:0]   imem_load,
    input  datapath_pkg::redirect_t           redirect,
    fetch_if.fetch                            fif,
    input  logic                              halt
);
    import datapath_pkg::*;

    logic [PC_W-1:0]   pc;
    logic              running;
    logic              latch_valid;
    logic [WORD_W-1:0] latch_instr;
    logic [PC_W-1:0]   latch_pc;
    logic              take;

    // request while the latch is empty or being drained this cycle
    assign imem_ren  = running && !halt && (!latch_valid || fif.ready);
    assign imem_addr = pc;
    assign take      = imem_ren && imem_hit;

    assign fif.valid = latch_valid;
    assign fif.instr = latch_instr;
    assign fif.pc    = latch_pc;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc          <= RESET_PC;
            running     <= 1'b0;
            latch_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect.taken) begin
                // a taken branch drops whatever is latched or arriving
                pc          <= redirect.target;
                latch_valid <= 1'b0;
            end else if (take) begin
                pc          <= pc + 1'b1;
                latch_valid <= 1'b1;
            end else if (fif.ready) begin
                latch_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            latch_instr <= imem_load;
            latch_pc    <= pc;
        end
    end

    // a waiting request stays up and keeps its address until the memory answers
    a_addr_stable: assert property (@(posedge CLK) disable iff (!nrst)
        imem_ren && !imem_hit && !redirect.taken |=>
            (imem_ren || halt) && imem_addr == $past(imem_addr));

endmodule

//--- logic/fetch_if.sv
// fetch to scoreboard bundle
`timescale 1ns/100ps

interface fetch_if;
    import datapath_pkg::*;

    logic              valid;
    logic              ready;
    logic [WORD_W-1:0] instr;
    logic [PC_W-1:0]   pc;

    modport fetch (
        output valid, instr, pc,
        input  ready
    );

    modport decode (
        input  valid, instr, pc,
        output ready
    );

endinterface

//--- logic/issue_if.sv
// scoreboard to execute bundle
`timescale 1ns/100ps

interface issue_if;
    import datapath_pkg::*;

    // execute takes a packet every cycle without ready
    logic   valid;
    issue_t pkt;

    modport decode (
        output valid, pkt
    );

    modport exec (
        input valid, pkt
    );

endinterface

//--- logic/result_if.sv
// result, redirect and register file bundles
`timescale 1ns/100ps

interface result_if;
    import datapath_pkg::*;

    logic      valid;
    result_t   res;
    redirect_t redir;

    modport exec   (output valid, res, redir);
    modport retire (input valid, res);
    // busy release and branch flush
    modport track  (input valid, res, redir);

endinterface

interface regfile_if;
    import datapath_pkg::*;

    logic [REG_W-1:0]  rsel1, rsel2;
    logic [WORD_W-1:0] rdat1, rdat2;

    modport read  (output rsel1, rsel2, input rdat1, rdat2);
    modport store (input rsel1, rsel2, output rdat1, rdat2);

endinterface

//--- logic/sc_datapath.sv
// scalar datapath top level
`timescale 1ns/100ps

module sc_datapath #(
    parameter logic [datapath_pkg::PC_W-1:0] RESET_PC = '0
) (
    input  logic                             CLK,
    input  logic                             nrst,
    output logic                             imem_ren,
    output logic [datapath_pkg::PC_W-1:0]    imem_addr,
    input  logic                             imem_hit,
    input  logic [datapath_pkg::WORD_W-1:0]  imem_load,
    output logic                             commit_en,
    output logic [datapath_pkg::REG_W-1:0]   commit_sel,
    output logic [datapath_pkg::WORD_W-1:0]  commit_data,
    output logic                             halt
);
    import datapath_pkg::*;

    fetch_if   fif();
    issue_if   iif();
    result_if  rif();
    regfile_if rfif();

    redirect_t redirect;
    logic      halted;

    // branch redirect goes back to fetch as a plain struct
    assign redirect = rif.redir;
    assign halt     = halted;

    fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .CLK       (CLK),
        .nrst      (nrst),
        .imem_ren  (imem_ren),
        .imem_addr (imem_addr),
        .imem_hit  (imem_hit),
        .imem_load (imem_load),
        .redirect  (redirect),
        .fif       (fif.fetch),
        .halt      (halted)
    );

    scoreboard u_scoreboard (
        .CLK  (CLK),
        .nrst (nrst),
        .fif  (fif.decode),
        .iif  (iif.decode),
        .rfif (rfif.read),
        .rif  (rif.track)
    );

    execute u_execute (
        .CLK  (CLK),
        .nrst (nrst),
        .iif  (iif.exec),
        .rif  (rif.exec)
    );

    writeback u_writeback (
        .CLK         (CLK),
        .nrst        (nrst),
        .rif         (rif.retire),
        .rfif        (rfif.store),
        .commit_en   (commit_en),
        .commit_sel  (commit_sel),
        .commit_data (commit_data),
        .halt        (halted)
    );

endmodule

//--- logic/scoreboard.sv
// decode, hazard check and issue
`timescale 1ns/100ps

module scoreboard (
    input logic       CLK,
    input logic       nrst,
    fetch_if.decode   fif,
    issue_if.decode   iif,
    regfile_if.read   rfif,
    result_if.track   rif
);
    import datapath_pkg::*;

    opcode_t           op;
    logic [REG_W-1:0]  rd, rs1, rs2;
    logic [WORD_W-1:0] imm_ext;
    logic              uses_rs1, uses_rs2, writes_rd;
    logic              is_branch, is_halt;
    logic [NREGS-1:0]  busy;
    logic              br_pend;
    logic              halted;
    logic              stall;
    logic              issue_go;
    logic              issue_valid;
    issue_t            issue_pkt;

    // field extraction
    assign op      = opcode_t'(fif.instr[OP_HI:OP_LO]);
    assign rd      = fif.instr[RD_HI:RD_LO];
    assign rs1     = fif.instr[RS1_HI:RS1_LO];
    assign rs2     = fif.instr[RS2_HI:RS2_LO];
    assign imm_ext = {{(WORD_W - (IMM_HI - IMM_LO + 1)){fif.instr[IMM_HI]}},
                      fif.instr[IMM_HI:IMM_LO]};

    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        is_halt   = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = (rd != '0);
            end
            OP_ADDI: begin
                uses_rs1  = 1'b1;
                writes_rd = (rd != '0);
            end
            OP_BEQ, OP_BNE: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                is_branch = 1'b1;
            end
            OP_HALT: is_halt = 1'b1;
            default: ;
        endcase
    end

    // issue holds while a branch sits in execute and resumes when its redirect shows
    assign stall = halted || br_pend ||
                   (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) ||
                   (writes_rd && busy[rd]);

    assign fif.ready = !stall;
    assign issue_go  = fif.valid && !stall && !rif.redir.taken;

    assign rfif.rsel1 = rs1;
    assign rfif.rsel2 = rs2;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy        <= '0;
            br_pend     <= 1'b0;
            halted      <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_go;
            if (rif.valid && rif.res.wen)
                busy[rif.res.rd] <= 1'b0;
            if (issue_go && writes_rd)
                busy[rd] <= 1'b1;
            br_pend <= issue_go && is_branch;
            if (issue_go && is_halt)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_go) begin
            issue_pkt.opcode <= op;
            issue_pkt.rd     <= rd;
            issue_pkt.rdat1  <= rfif.rdat1;
            issue_pkt.rdat2  <= rfif.rdat2;
            issue_pkt.imm    <= imm_ext;
            issue_pkt.pc     <= fif.pc;
        end
    end

    assign iif.valid = issue_valid;
    assign iif.pkt   = issue_pkt;

    // a source is never the destination of the result still waiting to retire
    a_no_busy_src: assert property (@(posedge CLK) disable iff (!nrst)
        issue_go && rif.valid && rif.res.wen |->
            !(uses_rs1 && rif.res.rd == rs1) && !(uses_rs2 && rif.res.rd == rs2));

endmodule

//--- logic/writeback.sv
// register file and retire
`timescale 1ns/100ps

module writeback (
    input  logic                             CLK,
    input  logic                             nrst,
    result_if.retire                         rif,
    regfile_if.store                         rfif,
    output logic                             commit_en,
    output logic [datapath_pkg::REG_W-1:0]   commit_sel,
    output logic [datapath_pkg::WORD_W-1:0]  commit_data,
    output logic                             halt
);
    import datapath_pkg::*;

    logic [WORD_W-1:0] regs [NREGS];
    logic              halt_q;

    // commit shows the retiring write in its own cycle
    assign commit_en   = rif.valid && rif.res.wen;
    assign commit_sel  = rif.res.rd;
    assign commit_data = rif.res.data;
    assign halt        = halt_q;

    always_ff @(posedge CLK) begin
        if (commit_en)
            regs[commit_sel] <= commit_data;
    end

    // register 0 reads zero
    assign rfif.rdat1 = (rfif.rsel1 == '0) ? '0 : regs[rfif.rsel1];
    assign rfif.rdat2 = (rfif.rsel2 == '0) ? '0 : regs[rfif.rsel2];

    // sticky once the halt mark retires
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst)
            halt_q <= 1'b0;
        else if (rif.valid && rif.res.halt)
            halt_q <= 1'b1;
    end

    a_commit_nonzero: assert property (@(posedge CLK) disable iff (!nrst)
        commit_en |-> commit_sel != '0);

endmodule

//--- tests/tb_sc_datapath.sv
// scalar datapath testbench
`timescale 1ns/100ps

module tb_sc_datapath;
    import datapath_pkg::*;

    localparam int PROG_LEN = 17;
    localparam int MAX_EXP  = 64;

    logic              CLK;
    logic              nrst;
    logic              imem_ren;
    logic [PC_W-1:0]   imem_addr;
    logic              imem_hit;
    logic [WORD_W-1:0] imem_load;
    logic              commit_en;
    logic [REG_W-1:0]  commit_sel;
    logic [WORD_W-1:0] commit_data;
    logic              halt;

    logic [WORD_W-1:0] prog [PROG_LEN];
    logic [REG_W-1:0]  exp_sel [MAX_EXP];
    logic [WORD_W-1:0] exp_data [MAX_EXP];
    int                exp_count;
    int                exp_steps;
    int                commit_idx;
    int                wait_left;
    integer            seed = 32'h3eb9_2a7b;
    logic              early;
    logic              ref_ready;
    int                reset_errs, order_errs, reg0_errs, halt_errs;
    int                failed_tests;

    sc_datapath #(.RESET_PC('0)) DUT (
        .CLK         (CLK),
        .nrst        (nrst),
        .imem_ren    (imem_ren),
        .imem_addr   (imem_addr),
        .imem_hit    (imem_hit),
        .imem_load   (imem_load),
        .commit_en   (commit_en),
        .commit_sel  (commit_sel),
        .commit_data (commit_data),
        .halt        (halt)
    );

    function automatic logic [WORD_W-1:0] encode(opcode_t op, int rd, int rs1, int rs2, int imm);
        encode = {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
    endfunction

    // addresses past the program read as ADDI r1 carrying the address
    function automatic logic [WORD_W-1:0] word_at(logic [PC_W-1:0] addr);
        if (addr < PROG_LEN)
            word_at = prog[addr];
        else
            word_at = encode(OP_ADDI, 1, 0, 0, int'(addr));
    endfunction

    task automatic load_program();
        prog[0]  = encode(OP_ADDI, 1, 0, 0, 5);     // r1 = 5
        prog[1]  = encode(OP_ADDI, 2, 1, 0, 3);     // r2 = 8
        prog[2]  = encode(OP_ADD,  3, 2, 1, 0);     // r3 = 13
        prog[3]  = encode(OP_SUB,  4, 3, 2, 0);     // r4 = 5
        prog[4]  = encode(OP_XOR,  5, 4, 1, 0);     // r5 = 0
        prog[5]  = encode(OP_BEQ,  0, 5, 0, 3);     // taken, to 8
        prog[6]  = encode(OP_ADDI, 6, 0, 0, 99);
        prog[7]  = encode(OP_ADDI, 7, 0, 0, 77);
        prog[8]  = encode(OP_OR,   6, 3, 2, 0);
        prog[9]  = encode(OP_AND,  7, 6, 1, 0);
        prog[10] = encode(OP_BNE,  0, 7, 4, 5);     // not taken
        prog[11] = encode(OP_ADDI, 0, 1, 0, 1);     // dropped write to r0
        prog[12] = encode(OP_ADDI, 2, 2, 0, -1);
        prog[13] = encode(OP_BNE,  0, 2, 0, -1);    // count r2 down to zero
        prog[14] = encode(OP_ADDI, 1, 1, 0, -6);
        prog[15] = encode(OP_HALT, 0, 0, 0, 0);
        prog[16] = encode(OP_ADDI, 3, 0, 0, 1);
    endtask

    // in-order interpreter of the program
    task automatic build_reference();
        logic [WORD_W-1:0] r [NREGS];
        logic [WORD_W-1:0] w, a, b, imm, res;
        logic [PC_W-1:0]   pc, npc;
        logic [REG_W-1:0]  rd;
        logic              wr, done;
        foreach (r[i])
            r[i] = '0;
        pc = '0;
        done = 1'b0;
        exp_count = 0;
        exp_steps = 0;
        while (!done && exp_steps < 1000) begin
            w   = word_at(pc);
            rd  = w[27:25];
            a   = r[w[24:22]];
            b   = r[w[21:19]];
            imm = {{16{w[15]}}, w[15:0]};
            npc = pc + 1'b1;
            wr  = 1'b1;
            res = '0;
            case (w[31:28])
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + imm;
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (w[31:28] == OP_BEQ))
                        npc = pc + imm[PC_W-1:0];
                end
                OP_HALT: begin
                    wr = 1'b0;
                    done = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != '0) begin
                r[rd] = res;
                exp_sel[exp_count] = rd;
                exp_data[exp_count] = res;
                exp_count++;
            end
            pc = npc;
            exp_steps++;
        end
    endtask

    task automatic report_test(string name, int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
            failed_tests++;
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // instruction memory answering after 0 to 3 cycles
    always @(negedge CLK) begin
        if (nrst && imem_ren && wait_left == 0) begin
            imem_hit  <= 1'b1;
            imem_load <= word_at(imem_addr);
            wait_left <= $unsigned($random(seed)) % 4;
        end else begin
            imem_hit <= 1'b0;
            if (nrst && imem_ren)
                wait_left <= wait_left - 1;
        end
    end

    always @(posedge CLK or negedge nrst) begin
        if (!nrst)
            commit_idx <= 0;
        else if (commit_en)
            commit_idx <= commit_idx + 1;
    end

    a_reset_quiet: assert property (@(posedge CLK) early |-> !imem_ren && !commit_en && !halt)
        else begin
            reset_errs++;
            $display("** Error: imem_ren = %h, commit_en = %h, halt = %h, expected 0",
                     $sampled(imem_ren), $sampled(commit_en), $sampled(halt));
        end

    a_commit_extra: assert property (@(posedge CLK) disable iff (!nrst)
        commit_en |-> commit_idx < exp_count)
        else begin
            order_errs++;
            $display("commit seen after all %0d reference commits", exp_count);
        end

    a_commit_value: assert property (@(posedge CLK) disable iff (!nrst)
        commit_en && commit_idx < exp_count |->
            commit_sel == exp_sel[commit_idx] && commit_data == exp_data[commit_idx])
        else begin
            order_errs++;
            $display("** Error: commit_sel = %h (expected %h), commit_data = %h (expected %h)",
                     $sampled(commit_sel), exp_sel[$sampled(commit_idx)],
                     $sampled(commit_data), exp_data[$sampled(commit_idx)]);
        end

    a_no_reg0: assert property (@(posedge CLK) disable iff (!nrst)
        commit_en |-> commit_sel != '0)
        else begin
            reg0_errs++;
            $display("** Error: commit_sel = %h, expected nonzero", $sampled(commit_sel));
        end

    a_halt_last: assert property (@(posedge CLK) disable iff (!nrst)
        $rose(halt) |-> commit_idx == exp_count)
        else begin
            halt_errs++;
            $display("** Error: commit count = %h at halt, expected %h",
                     $sampled(commit_idx), exp_count);
        end

    a_halt_sticky: assert property (@(posedge CLK) disable iff (!nrst) halt |=> halt)
        else begin
            halt_errs++;
            $display("halt dropped after rising");
        end

    a_halt_quiet: assert property (@(posedge CLK) disable iff (!nrst) halt |-> !commit_en)
        else begin
            halt_errs++;
            $display("commit seen after halt");
        end

    initial begin
        nrst = 1'b0;
        imem_hit = 1'b0;
        imem_load = '0;
        early = 1'b0;
        ref_ready = 1'b0;
        reset_errs = 0;
        order_errs = 0;
        reg0_errs = 0;
        halt_errs = 0;
        failed_tests = 0;
        load_program();
        build_reference();
        wait_left = $unsigned($random(seed)) % 4;
        ref_ready = 1'b1;
        // outputs are defined from the first clock edge in reset
        @(negedge CLK);
        early = 1'b1;
        repeat (7) @(negedge CLK);
        nrst = 1'b1;
        @(negedge CLK);
        early = 1'b0;
        report_test("reset_quiet", reset_errs);
        wait (halt === 1'b1);
        repeat (4) @(negedge CLK);
        a_commit_count: assert (commit_idx == exp_count)
            else begin
                halt_errs++;
                $display("** Error: commit count = %h, expected %h", commit_idx, exp_count);
            end
        report_test("commit_order", order_errs);
        report_test("register_zero", reg0_errs);
        report_test("halt", halt_errs);
        $display("tests: 4, failed: %0d, errors: %0d", failed_tests,
                 reset_errs + order_errs + reg0_errs + halt_errs);
        if (failed_tests == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog scaled by the reference instruction count
    initial begin
        wait (ref_ready);
        #((exp_steps * 40 + 8) * 20);
        $display("timeout, halt did not rise within %0d cycles", exp_steps * 40 + 8);
        $display("Simulation failed");
        $finish;
    end

endmodule
